// File: hw/decode_pkg.sv
package decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 4;  // 16 registers
    localparam int OPCODE_W  = 7;

    // RV32I major opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011,  // Rejected
        OPC_FENCE  = 7'b0001111   // Rejected
    } opcode_e;

    // CLASS_ILLEGAL must stay last
    typedef enum logic [3:0] {
        CLASS_OP,
        CLASS_OP_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_BRANCH,
        CLASS_ILLEGAL
    } instr_class_e;

    // Same bit order as instr[31:7]
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
    } instr_fields_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2,
        WB_NPC = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        PC_NPC     = 2'd0,
        PC_REG_IMM = 2'd1,  // JALR target
        PC_PC_IMM  = 2'd2,  // JAL target
        PC_BRANCH  = 2'd3   // Taken only if condition holds
    } pc_sel_e;

    typedef struct packed {
        logic                 enable;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
    } rf_read_uop_t;

    typedef struct packed {
        logic       enable;
        logic       is_branch;
        logic       alt;  // SUB or SRA
        logic [2:0] op;
    } alu_uop_t;

    typedef struct packed {
        logic       enable;
        logic       is_store;
        logic [2:0] size;
    } mem_uop_t;

    typedef struct packed {
        logic                 enable;
        logic [REG_IDX_W-1:0] rd;
    } rf_write_uop_t;

    typedef struct packed {
        rf_read_uop_t  rf_read;
        alu_uop_t      alu;
        mem_uop_t      mem;
        rf_write_uop_t rf_write;
        logic          alu_a_is_pc;
        logic          alu_b_is_imm;
        wb_sel_e       wb_sel;
        pc_sel_e       pc_sel;
    } decoded_uops_t;

endpackage

// File: hw/field_split_stage.sv
`timescale 1ns/100ps

module field_split_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  logic [decode_pkg::XLEN-1:0] instr,
    output logic                        s1_valid,
    output decode_pkg::instr_class_e    s1_class,
    output decode_pkg::instr_fields_t   s1_fields
);
    import decode_pkg::*;

    opcode_e       opcode;
    instr_class_e  class_d;
    instr_fields_t fields_d;

    assign opcode = opcode_e'(instr[OPCODE_W-1:0]);

    always_comb begin
        fields_d.funct7 = instr[31:25];
        fields_d.rs2    = instr[24:20];
        fields_d.rs1    = instr[19:15];
        fields_d.funct3 = instr[14:12];
        fields_d.rd     = instr[11:7];
    end

    always_comb begin
        case (opcode)
            OPC_OP:                class_d = CLASS_OP;
            OPC_OP_IMM:            class_d = CLASS_OP_IMM;
            OPC_LOAD:              class_d = CLASS_LOAD;
            OPC_STORE:             class_d = CLASS_STORE;
            OPC_LUI:               class_d = CLASS_LUI;
            OPC_AUIPC:             class_d = CLASS_AUIPC;
            OPC_JAL:               class_d = CLASS_JAL;
            OPC_JALR:              class_d = CLASS_JALR;
            OPC_BRANCH:            class_d = CLASS_BRANCH;
            OPC_SYSTEM, OPC_FENCE: class_d = CLASS_ILLEGAL;  // Not supported
            default:               class_d = CLASS_ILLEGAL;
        endcase
        if (instr[1:0] != 2'b11) begin
            class_d = CLASS_ILLEGAL;  // Compressed or reserved encoding
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= instr_valid;
        end
        s1_class  <= class_d;  // Qualified by s1_valid
        s1_fields <= fields_d;
    end

    a_class_defined: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(s1_class) && (s1_class <= CLASS_ILLEGAL));

endmodule

// File: hw/imm_stage.sv
`timescale 1ns/100ps

module imm_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s1_valid,
    input  decode_pkg::instr_class_e    s1_class,
    input  decode_pkg::instr_fields_t   s1_fields,
    output logic                        s2_valid,
    output decode_pkg::instr_class_e    s2_class,
    output decode_pkg::instr_fields_t   s2_fields,
    output logic [decode_pkg::XLEN-1:0] s2_imm
);
    import decode_pkg::*;

    logic [XLEN-1:7] raw;  // Instruction word without the opcode
    logic [XLEN-1:0] imm_d;

    assign raw = s1_fields;

    always_comb begin
        case (s1_class)
            CLASS_OP_IMM, CLASS_LOAD, CLASS_JALR: begin
                imm_d = {{20{raw[31]}}, raw[31:20]};
            end
            CLASS_STORE: begin
                imm_d = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            end
            CLASS_BRANCH: begin
                imm_d = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            CLASS_LUI, CLASS_AUIPC: begin
                imm_d = {raw[31:12], 12'b0};
            end
            CLASS_JAL: begin
                imm_d = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            default: begin
                imm_d = '0;  // OP and illegal words
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
        s2_class  <= s1_class;
        s2_fields <= s1_fields;
        s2_imm    <= imm_d;
    end

endmodule

// File: hw/uop_stage.sv
`timescale 1ns/100ps

module uop_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s2_valid,
    input  decode_pkg::instr_class_e    s2_class,
    input  decode_pkg::instr_fields_t   s2_fields,
    input  logic [decode_pkg::XLEN-1:0] s2_imm,
    output logic                        out_valid,
    output logic                        fault,
    output logic [decode_pkg::XLEN-1:0] imm,
    output decode_pkg::decoded_uops_t   uops
);
    import decode_pkg::*;

    logic [6:0]    funct7;
    logic [2:0]    funct3;
    logic          bad_rs1;
    logic          bad_rs2;
    logic          bad_rd;
    logic          bad_funct3;
    logic          bad_funct7;
    logic          fault_d;
    decoded_uops_t uops_raw;
    decoded_uops_t uops_d;

    assign funct7 = s2_fields.funct7;
    assign funct3 = s2_fields.funct3;

    always_comb begin
        uops_raw = '0;
        uops_raw.rf_read.rs1   = s2_fields.rs1[REG_IDX_W-1:0];
        uops_raw.rf_read.rs2   = s2_fields.rs2[REG_IDX_W-1:0];
        uops_raw.mem.size      = funct3;
        uops_raw.rf_write.rd   = s2_fields.rd[REG_IDX_W-1:0];
        uops_raw.alu_b_is_imm  = (s2_class != CLASS_OP) && (s2_class != CLASS_BRANCH);
        uops_raw.wb_sel        = WB_ALU;
        uops_raw.pc_sel        = PC_NPC;
        case (s2_class)
            CLASS_OP: begin
                uops_raw.rf_read.enable  = 1'b1;
                uops_raw.alu.enable      = 1'b1;
                uops_raw.alu.alt         = funct7[5] & (funct3 == 3'd0 || funct3 == 3'd5);
                uops_raw.alu.op          = funct3;
                uops_raw.rf_write.enable = 1'b1;
            end
            CLASS_OP_IMM: begin
                uops_raw.rf_read.enable  = 1'b1;
                uops_raw.alu.enable      = 1'b1;
                uops_raw.alu.alt         = funct7[5] & (funct3 == 3'd5);  // SRAI
                uops_raw.alu.op          = funct3;
                uops_raw.rf_write.enable = 1'b1;
            end
            CLASS_LOAD: begin
                uops_raw.rf_read.enable  = 1'b1;
                uops_raw.alu.enable      = 1'b1;  // Address add
                uops_raw.mem.enable      = 1'b1;
                uops_raw.rf_write.enable = 1'b1;
                uops_raw.wb_sel          = WB_MEM;
            end
            CLASS_STORE: begin
                uops_raw.rf_read.enable = 1'b1;
                uops_raw.alu.enable     = 1'b1;
                uops_raw.mem.enable     = 1'b1;
                uops_raw.mem.is_store   = 1'b1;
            end
            CLASS_LUI: begin
                uops_raw.rf_write.enable = 1'b1;
                uops_raw.wb_sel          = WB_IMM;
            end
            CLASS_AUIPC: begin
                uops_raw.alu.enable      = 1'b1;
                uops_raw.rf_write.enable = 1'b1;
                uops_raw.alu_a_is_pc     = 1'b1;
            end
            CLASS_JAL: begin
                uops_raw.rf_write.enable = 1'b1;
                uops_raw.wb_sel          = WB_NPC;  // Link address
                uops_raw.pc_sel          = PC_PC_IMM;
            end
            CLASS_JALR: begin
                uops_raw.rf_read.enable  = 1'b1;
                uops_raw.alu.enable      = 1'b1;
                uops_raw.rf_write.enable = 1'b1;
                uops_raw.wb_sel          = WB_NPC;
                uops_raw.pc_sel          = PC_REG_IMM;
            end
            CLASS_BRANCH: begin
                uops_raw.rf_read.enable = 1'b1;
                uops_raw.alu.enable     = 1'b1;
                uops_raw.alu.is_branch  = 1'b1;
                uops_raw.alu.op         = funct3;
                uops_raw.pc_sel         = PC_BRANCH;
            end
            default: begin
            end
        endcase
    end

    // Only x0..x15 exist
    assign bad_rs1 = uops_raw.rf_read.enable & s2_fields.rs1[4];
    assign bad_rs2 = (s2_class == CLASS_OP || s2_class == CLASS_STORE ||
                      s2_class == CLASS_BRANCH) & s2_fields.rs2[4];
    assign bad_rd  = uops_raw.rf_write.enable & s2_fields.rd[4];

    always_comb begin
        bad_funct3 = 1'b0;
        bad_funct7 = 1'b0;
        case (s2_class)
            CLASS_STORE:  bad_funct3 = funct3[2] | (funct3 == 3'd3);
            CLASS_LOAD:   bad_funct3 = (funct3 == 3'd3) | (funct3[2:1] == 2'b11);
            CLASS_JALR:   bad_funct3 = (funct3 != 3'd0);
            CLASS_BRANCH: bad_funct3 = (funct3[2:1] == 2'b01);
            CLASS_OP: begin
                bad_funct7 = |(funct7 & 7'b1011111) |
                             (funct7[5] & (funct3 != 3'd0) & (funct3 != 3'd5));
            end
            CLASS_OP_IMM: begin
                bad_funct7 = ((funct3 == 3'd1) & (funct7 != 7'd0)) |
                             ((funct3 == 3'd5) & (funct7 != 7'd0) & (funct7 != 7'd32));
            end
            default: begin
            end
        endcase
    end

    assign fault_d = (s2_class == CLASS_ILLEGAL) | bad_rs1 | bad_rs2 | bad_rd |
                     bad_funct3 | bad_funct7;

    always_comb begin
        uops_d = uops_raw;
        if (fault_d) begin
            uops_d.rf_read.enable  = 1'b0;
            uops_d.alu.enable      = 1'b0;
            uops_d.mem.enable      = 1'b0;
            uops_d.rf_write.enable = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            fault     <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            fault     <= s2_valid & fault_d;
        end
        imm  <= s2_imm;
        uops <= uops_d;
    end

    a_fault_kills_uops: assert property (@(posedge clk) disable iff (reset)
        (out_valid && fault) |-> !(uops.rf_read.enable || uops.alu.enable ||
                                   uops.mem.enable || uops.rf_write.enable));

endmodule

// File: hw/instruction_decoder.sv
`timescale 1ns/100ps

module instruction_decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  logic [decode_pkg::XLEN-1:0] instr,
    output logic                        out_valid,
    output logic                        fault,
    output logic [decode_pkg::XLEN-1:0] imm,
    output decode_pkg::decoded_uops_t   uops
);
    import decode_pkg::*;

    logic            s1_valid;
    instr_class_e    s1_class;
    instr_fields_t   s1_fields;
    logic            s2_valid;
    instr_class_e    s2_class;
    instr_fields_t   s2_fields;
    logic [XLEN-1:0] s2_imm;

    field_split_stage u_field_split_stage (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .s1_valid    (s1_valid),
        .s1_class    (s1_class),
        .s1_fields   (s1_fields)
    );

    imm_stage u_imm_stage (
        .clk       (clk),
        .reset     (reset),
        .s1_valid  (s1_valid),
        .s1_class  (s1_class),
        .s1_fields (s1_fields),
        .s2_valid  (s2_valid),
        .s2_class  (s2_class),
        .s2_fields (s2_fields),
        .s2_imm    (s2_imm)
    );

    uop_stage u_uop_stage (
        .clk       (clk),
        .reset     (reset),
        .s2_valid  (s2_valid),
        .s2_class  (s2_class),
        .s2_fields (s2_fields),
        .s2_imm    (s2_imm),
        .out_valid (out_valid),
        .fault     (fault),
        .imm       (imm),
        .uops      (uops)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;  // 40 ns period

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: test/tb_instruction_decoder.sv
`timescale 1ns/100ps

module tb_instruction_decoder;
    import decode_pkg::*;

    logic            clk;
    logic            reset;
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic            out_valid;
    logic            fault;
    logic [XLEN-1:0] imm;
    decoded_uops_t   uops;

    logic [31:0]   row_instr[$];
    logic          row_fault[$];
    logic [31:0]   row_imm[$];
    decoded_uops_t row_uops[$];
    int            issue_cycle[$];
    int            num_rows      = 0;
    int            issued        = 0;
    int            next_out      = 0;
    int            cycle_count   = 0;
    int            timeout_limit = 0;
    logic          started       = 1'b0;

    tb_clock_gen u_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    instruction_decoder u_instruction_decoder (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .out_valid   (out_valid),
        .fault       (fault),
        .imm         (imm),
        .uops        (uops)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic add_row(input logic [31:0] word, input logic [31:0] imm_exp,
                           input int rd_en, rs1, rs2, input int alu_en, br, alt, op,
                           input int mem_en, st, size, input int wr_en, rd,
                           input int a_pc, b_imm, input wb_sel_e wb, input pc_sel_e pc);
        decoded_uops_t u;
        u                 = '0;
        u.rf_read.enable  = 1'(rd_en);
        u.rf_read.rs1     = 4'(rs1);
        u.rf_read.rs2     = 4'(rs2);
        u.alu.enable      = 1'(alu_en);
        u.alu.is_branch   = 1'(br);
        u.alu.alt         = 1'(alt);
        u.alu.op          = 3'(op);
        u.mem.enable      = 1'(mem_en);
        u.mem.is_store    = 1'(st);
        u.mem.size        = 3'(size);
        u.rf_write.enable = 1'(wr_en);
        u.rf_write.rd     = 4'(rd);
        u.alu_a_is_pc     = 1'(a_pc);
        u.alu_b_is_imm    = 1'(b_imm);
        u.wb_sel          = wb;
        u.pc_sel          = pc;
        row_instr.push_back(word);
        row_fault.push_back(1'b0);
        row_imm.push_back(imm_exp);
        row_uops.push_back(u);
    endtask

    task automatic add_fault_row(input logic [31:0] word);
        row_instr.push_back(word);
        row_fault.push_back(1'b1);
        row_imm.push_back(32'h0);
        row_uops.push_back('0);  // All enables off
    endtask

    task automatic build_table();
        // word, imm, rf_read en/rs1/rs2, alu en/br/alt/op, mem en/st/size, rf_write en/rd,
        // alu_a_is_pc, alu_b_is_imm, wb_sel, pc_sel
        add_row(32'h002081b3, 32'h0, 1,1,2, 1,0,0,0, 0,0,0, 1,3, 0,0, WB_ALU, PC_NPC);  // add
        add_row(32'h407302b3, 32'h0, 1,6,7, 1,0,1,0, 0,0,0, 1,5, 0,0, WB_ALU, PC_NPC);  // sub
        add_row(32'h00b564b3, 32'h0, 1,10,11, 1,0,0,6, 0,0,0, 1,9, 0,0, WB_ALU, PC_NPC);
        add_row(32'hfff10093, 32'hffffffff, 1,2,15, 1,0,0,0, 0,0,0, 1,1, 0,1, WB_ALU, PC_NPC);
        add_row(32'h4032d213, 32'h403, 1,5,3, 1,0,1,5, 0,0,0, 1,4, 0,1, WB_ALU, PC_NPC);  // srai
        add_row(32'h00439313, 32'h4, 1,7,4, 1,0,0,1, 0,0,0, 1,6, 0,1, WB_ALU, PC_NPC);
        add_row(32'h00c4a403, 32'hc, 1,9,12, 1,0,0,0, 1,0,2, 1,8, 0,1, WB_MEM, PC_NPC);  // lw
        add_row(32'hffc1c103, 32'hfffffffc, 1,3,12, 1,0,0,0, 1,0,4, 1,2, 0,1, WB_MEM, PC_NPC);
        add_row(32'h00532423, 32'h8, 1,6,5, 1,0,0,0, 1,1,2, 0,0, 0,1, WB_ALU, PC_NPC);  // sw
        add_row(32'hfe110fa3, 32'hffffffff, 1,2,1, 1,0,0,0, 1,1,0, 0,0, 0,1, WB_ALU, PC_NPC);
        add_row(32'h123453b7, 32'h12345000, 0,0,0, 0,0,0,0, 0,0,0, 1,7, 0,1, WB_IMM, PC_NPC);
        add_row(32'hfffff497, 32'hfffff000, 0,0,0, 1,0,0,0, 0,0,0, 1,9, 1,1, WB_ALU, PC_NPC);
        add_row(32'hff9ff0ef, 32'hfffffff8, 0,0,0, 0,0,0,0, 0,0,0, 1,1, 0,1, WB_NPC, PC_PC_IMM);
        add_row(32'h00408067, 32'h4, 1,1,4, 1,0,0,0, 0,0,0, 1,0, 0,1, WB_NPC, PC_REG_IMM);
        add_row(32'hfe2088e3, 32'hfffffff0, 1,1,2, 1,1,0,0, 0,0,0, 0,0, 0,0, WB_ALU, PC_BRANCH);
        add_row(32'h0041f463, 32'h8, 1,3,4, 1,1,0,7, 0,0,0, 0,0, 0,0, WB_ALU, PC_BRANCH);
        add_fault_row(32'h00013083);  // Load funct3 3
        add_fault_row(32'h000090e7);  // Jalr funct3 1
        add_fault_row(32'h023100b3);  // Funct7 bit 0
        add_fault_row(32'h40111093);  // Slli with funct7 32
        add_fault_row(32'h0100a023);  // Store from x16
        add_fault_row(32'h00100a13);  // Addi into x20
        add_fault_row(32'h00000073);  // Ecall
        add_fault_row(32'h300110f3);  // Csrrw
        add_fault_row(32'h0ff0000f);  // Fence
        add_fault_row(32'h002081b0);  // Low bits 00
    endtask

    task automatic compare_row(input int idx);
        decoded_uops_t exp;
        string         tag;
        exp = row_uops[idx];
        tag = $sformatf("row %0d ", idx);
        check_value({tag, "latency"}, cycle_count - issue_cycle[idx], 3);
        check_value({tag, "fault"}, 32'(fault), 32'(row_fault[idx]));
        check_value({tag, "rf_read.enable"}, 32'(uops.rf_read.enable), 32'(exp.rf_read.enable));
        check_value({tag, "alu.enable"}, 32'(uops.alu.enable), 32'(exp.alu.enable));
        check_value({tag, "mem.enable"}, 32'(uops.mem.enable), 32'(exp.mem.enable));
        check_value({tag, "rf_write.enable"}, 32'(uops.rf_write.enable),
                    32'(exp.rf_write.enable));
        if (!row_fault[idx]) begin
            check_value({tag, "imm"}, imm, row_imm[idx]);
            if (exp.rf_read.enable) begin
                check_value({tag, "rf_read.rs1"}, 32'(uops.rf_read.rs1), 32'(exp.rf_read.rs1));
                check_value({tag, "rf_read.rs2"}, 32'(uops.rf_read.rs2), 32'(exp.rf_read.rs2));
            end
            check_value({tag, "alu"}, 32'(uops.alu), 32'(exp.alu));
            check_value({tag, "mem.is_store"}, 32'(uops.mem.is_store), 32'(exp.mem.is_store));
            if (exp.mem.enable) begin
                check_value({tag, "mem.size"}, 32'(uops.mem.size), 32'(exp.mem.size));
            end
            if (exp.rf_write.enable) begin
                check_value({tag, "rf_write.rd"}, 32'(uops.rf_write.rd), 32'(exp.rf_write.rd));
            end
            check_value({tag, "alu_a_is_pc"}, 32'(uops.alu_a_is_pc), 32'(exp.alu_a_is_pc));
            check_value({tag, "alu_b_is_imm"}, 32'(uops.alu_b_is_imm), 32'(exp.alu_b_is_imm));
            check_value({tag, "wb_sel"}, 32'(uops.wb_sel), 32'(exp.wb_sel));
            check_value({tag, "pc_sel"}, 32'(uops.pc_sel), 32'(exp.pc_sel));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d rows matched",
                               cycle_count, next_out, num_rows));
        end
    end

    // Outputs sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        if (cycle_count > 0) begin  // Outputs unknown before the first rising edge
            if (reset || !started) begin
                check_value("idle out_valid", 32'(out_valid), 32'h0);
                check_value("idle fault", 32'(fault), 32'h0);
            end else if (out_valid) begin
                if (next_out >= issued) begin
                    fail_run("out_valid was high with no instruction outstanding");
                end else begin
                    compare_row(next_out);
                    next_out = next_out + 1;
                end
            end else if (next_out < issued && cycle_count - issue_cycle[next_out] >= 3) begin
                fail_run($sformatf("out_valid never came for row %0d", next_out));
            end
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        num_rows      = row_instr.size();
        timeout_limit = 16 + num_rows + 3 + 20;
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        repeat (2) @(negedge clk);  // Idle cycles after reset
        for (int i = 0; i < num_rows; i++) begin
            instr_valid = 1'b1;
            instr       = row_instr[i];
            issue_cycle.push_back(cycle_count);
            issued  = issued + 1;
            started = 1'b1;
            @(negedge clk);
        end
        instr_valid = 1'b0;
        instr       = '0;
        wait (next_out == num_rows);
        repeat (5) @(negedge clk);  // Catch any late extra out_valid
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: filelist.f
hw/decode_pkg.sv
hw/field_split_stage.sv
hw/imm_stage.sv
hw/uop_stage.sv
hw/instruction_decoder.sv
test/tb_clock_gen.sv
test/tb_instruction_decoder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_instruction_decoder
FILELIST  ?= filelist.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
